/* Makefile */
VERILATOR  ?= verilator
TOP        := dcache_tb
FLIST      := compile.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
logic/dcache_pkg.sv
logic/dcache_lookup.sv
logic/dcache_miss_ctrl.sv
logic/dcache_data_store.sv
logic/dcache_top.sv
tests/dcache_tb.sv

/* logic/dcache_data_store.sv */
`timescale 1ns/1ps

module dcache_data_store #(
    parameter int SETS = 64
) (
    input  logic                          I_clk,
    input  logic                          I_rst,
    input  dcache_pkg::cpu_req_t          cpu_req,
    input  dcache_pkg::lookup_t           lookup,
    input  dcache_pkg::store_ctrl_t       ctrl,
    input  logic [dcache_pkg::DATA_W-1:0] rdata,
    output logic [dcache_pkg::DATA_W-1:0] cpu_rdata,
    output logic [dcache_pkg::DATA_W-1:0] wb_data
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    typedef logic [BEATS-1:0][DATA_W-1:0] line_t;

    line_t             way_mem [2][SETS];
    line_t             fill_buf;
    line_t             alloc_line;
    line_t             hit_line;
    logic [DATA_W-1:0] wdata_q;
    logic [7:0]        wmask_q;
    logic [IDX_W-1:0]  idx;

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [7:0]        mask);
        logic [DATA_W-1:0] res;
        res = old_word;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign idx      = lookup.line_addr[OFFS_W +: IDX_W];
    assign hit_line = way_mem[lookup.hit_way][idx];

    // refill line with the pending write folded in
    always_comb begin
        alloc_line = fill_buf;
        alloc_line[lookup.word_sel] = merge_bytes(fill_buf[lookup.word_sel], wdata_q, wmask_q);
    end

    assign cpu_rdata = ctrl.hit_read ? hit_line[lookup.word_sel] : fill_buf[lookup.word_sel];
    assign wb_data   = way_mem[lookup.victim_way][idx][ctrl.wb_beat];

    always_ff @(posedge I_clk) begin
        if (ctrl.capture) begin
            wdata_q <= cpu_req.wdata;
            // reads leave the refill line untouched at allocation
            wmask_q <= cpu_req.wr_req ? cpu_req.wmask : '0;
        end
        // first beat ends up in word 0
        if (ctrl.fill_beat) begin
            fill_buf <= {rdata, fill_buf[BEATS-1:1]};
        end
    end

    always_ff @(posedge I_clk) begin
        if (ctrl.allocate) begin
            way_mem[lookup.victim_way][idx] <= alloc_line;
        end
        for (int w = 0; w < 2; w++) begin
            if (ctrl.wr_hit_way[w]) begin
                way_mem[w][idx][lookup.word_sel] <=
                    merge_bytes(way_mem[w][idx][lookup.word_sel], wdata_q, wmask_q);
            end
        end
    end

    // a merge follows right after a capture or an allocation
    assert property (@(posedge I_clk) disable iff (I_rst)
        ctrl.wr_hit_way != 2'b00 |-> $past(ctrl.capture) || $past(ctrl.allocate));

endmodule

/* logic/dcache_lookup.sv */
`timescale 1ns/1ps

module dcache_lookup #(
    parameter int SETS = 64
) (
    input  logic                 I_clk,
    input  logic                 I_rst,
    input  dcache_pkg::cpu_req_t cpu_req,
    input  logic                 accept,
    input  logic                 allocate,
    input  logic                 clean_victim,
    output dcache_pkg::lookup_t  lookup
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - OFFS_W - IDX_W;

    logic [TAG_W-1:0] tag_mem [2][SETS];
    logic [SETS-1:0]  valid_q [2];
    logic [SETS-1:0]  dirty_q [2];
    // latched request was a write
    logic             wr_q;

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] cur_idx;
    logic [TAG_W-1:0] cur_tag;
    logic [1:0]       way_hit;
    logic             victim;

    assign req_idx = cpu_req.addr[OFFS_W +: IDX_W];
    assign req_tag = cpu_req.addr[ADDR_W-1 -: TAG_W];
    assign cur_idx = lookup.line_addr[OFFS_W +: IDX_W];
    assign cur_tag = lookup.line_addr[ADDR_W-1 -: TAG_W];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][req_idx] && (tag_mem[w][req_idx] == req_tag);
        end
    end

    // hit way first, then an empty way 1, else way 0
    always_comb begin
        if (|way_hit) begin
            victim = way_hit[1];
        end else begin
            victim = valid_q[0][req_idx] && !valid_q[1][req_idx];
        end
    end

    always_ff @(posedge I_clk) begin
        if (accept) begin
            lookup.hit          <= |way_hit;
            lookup.hit_way      <= way_hit[1];
            lookup.victim_way   <= victim;
            lookup.victim_dirty <= dirty_q[victim][req_idx];
            lookup.victim_addr  <= {tag_mem[victim][req_idx], req_idx, {OFFS_W{1'b0}}};
            lookup.line_addr    <= {cpu_req.addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
            lookup.word_sel     <= cpu_req.addr[OFFS_W-1 -: WORD_SEL_W];
            wr_q                <= cpu_req.wr_req;
        end else if (allocate) begin
            // line is now resident in the victim way
            lookup.hit     <= 1'b1;
            lookup.hit_way <= lookup.victim_way;
        end
    end

    always_ff @(posedge I_clk) begin
        if (allocate) begin
            tag_mem[lookup.victim_way][cur_idx] <= cur_tag;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            if (accept && cpu_req.wr_req && (|way_hit)) begin
                dirty_q[way_hit[1]][req_idx] <= 1'b1;
            end
            // victim written back to memory
            if (clean_victim) begin
                dirty_q[lookup.victim_way][cur_idx] <= 1'b0;
            end
            if (allocate) begin
                valid_q[lookup.victim_way][cur_idx] <= 1'b1;
                dirty_q[lookup.victim_way][cur_idx] <= wr_q;
            end
        end
    end

    // a tag lives in at most one way of a set
    assert property (@(posedge I_clk) disable iff (I_rst) accept |-> !(&way_hit));

endmodule

/* logic/dcache_miss_ctrl.sv */
`timescale 1ns/1ps

module dcache_miss_ctrl (
    input  logic                    I_clk,
    input  logic                    I_rst,
    input  dcache_pkg::cpu_req_t    cpu_req,
    input  dcache_pkg::lookup_t     lookup,
    input  logic                    arready,
    input  logic                    rvalid,
    input  logic                    rlast,
    input  logic                    awready,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    accept,
    output logic                    cpu_ready,
    output logic                    cpu_rvalid,
    output logic                    cpu_bvalid,
    output logic                    allocate,
    output logic                    clean_victim,
    output dcache_pkg::store_ctrl_t ctrl,
    output dcache_pkg::mem_rd_t     mem_rd,
    output dcache_pkg::mem_wr_t     mem_wr
);
    import dcache_pkg::*;

    cache_state_e          state_q;
    cache_state_e          state_d;
    wb_state_e             wb_q;
    wb_state_e             wb_d;
    logic [WORD_SEL_W-1:0] beat_q;

    logic in_wb;
    logic in_reload;
    logic ar_done;
    logic refill_done;
    logic w_fire;
    logic wb_done;

    // RD_HIT and WR_HIT turn out to be misses when the lookup says so
    assign cpu_ready  = (state_q == IDLE)
                     || ((state_q == RD_HIT || state_q == WR_HIT) && lookup.hit);
    assign accept     = cpu_ready && (cpu_req.rd_req || cpu_req.wr_req);
    assign cpu_rvalid = (state_q == RD_HIT && lookup.hit) || state_q == RD_ALLOCATE;
    assign cpu_bvalid = state_q == WR_HIT && lookup.hit;
    assign allocate   = state_q == RD_ALLOCATE || state_q == WR_ALLOCATE;

    assign in_wb       = state_q == RD_WB || state_q == WR_WB;
    assign in_reload   = state_q == RD_RELOAD || state_q == WR_RELOAD;
    assign ar_done     = mem_rd.arvalid && arready;
    assign refill_done = in_reload && rvalid && rlast;
    assign w_fire      = mem_wr.wvalid && wready;
    // B may come with the last W beat
    assign wb_done     = (w_fire && mem_wr.wlast && bvalid) || (wb_q == WB_RESP && bvalid);
    assign clean_victim = wb_done;

    assign mem_rd.araddr  = lookup.line_addr;
    assign mem_rd.arvalid = state_q == RD_MISS || state_q == WR_MISS;

    // wdata is filled in from the data store at the top
    assign mem_wr.awaddr  = lookup.victim_addr;
    assign mem_wr.awvalid = wb_q == WB_ADDR;
    assign mem_wr.wdata   = '0;
    assign mem_wr.wvalid  = wb_q == WB_DATA;
    assign mem_wr.wlast   = mem_wr.wvalid && (beat_q == WORD_SEL_W'(BEATS - 1));

    always_comb begin
        ctrl.fill_beat  = in_reload && rvalid;
        ctrl.capture    = accept;
        ctrl.hit_read   = state_q == RD_HIT && lookup.hit;
        ctrl.wr_hit_way = '0;
        ctrl.wr_hit_way[lookup.hit_way] = cpu_bvalid;
        ctrl.allocate   = allocate;
        ctrl.wb_beat    = beat_q;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, RD_HIT, WR_HIT: begin
                if (state_q != IDLE && !lookup.hit) begin
                    state_d = (state_q == RD_HIT) ? RD_MISS : WR_MISS;
                end else if (accept) begin
                    state_d = cpu_req.rd_req ? RD_HIT : WR_HIT;
                end else begin
                    state_d = IDLE;
                end
            end
            RD_MISS:     state_d = ar_done ? RD_RELOAD : RD_MISS;
            RD_RELOAD: begin
                if (refill_done) begin
                    state_d = lookup.victim_dirty ? RD_WB : RD_ALLOCATE;
                end
            end
            RD_WB:       state_d = wb_done ? RD_ALLOCATE : RD_WB;
            RD_ALLOCATE: state_d = IDLE;
            WR_MISS:     state_d = ar_done ? WR_RELOAD : WR_MISS;
            WR_RELOAD: begin
                if (refill_done) begin
                    state_d = lookup.victim_dirty ? WR_WB : WR_ALLOCATE;
                end
            end
            WR_WB:       state_d = wb_done ? WR_ALLOCATE : WR_WB;
            WR_ALLOCATE: state_d = WR_HIT;
            default:     state_d = IDLE;
        endcase
    end

    // write-back runs while the main FSM waits in RD_WB or WR_WB
    always_comb begin
        wb_d = wb_q;
        case (wb_q)
            WB_IDLE: wb_d = in_wb ? WB_ADDR : WB_IDLE;
            WB_ADDR: wb_d = awready ? WB_DATA : WB_ADDR;
            WB_DATA: begin
                if (w_fire && mem_wr.wlast) begin
                    wb_d = bvalid ? WB_IDLE : WB_RESP;
                end
            end
            WB_RESP: wb_d = bvalid ? WB_IDLE : WB_RESP;
            default: wb_d = WB_IDLE;
        endcase
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state_q <= IDLE;
            wb_q    <= WB_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            wb_q    <= wb_d;
            if (w_fire) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    assert property (@(posedge I_clk) disable iff (I_rst)
        !(mem_rd.arvalid && mem_wr.awvalid));

    // W beats only inside a write-back of the main FSM
    assert property (@(posedge I_clk) disable iff (I_rst)
        mem_wr.wvalid |-> in_wb);

endmodule

/* logic/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int LINE_BYTES = 32;
    localparam int BEATS      = 4;
    localparam int OFFS_W     = 5;
    localparam int WORD_SEL_W = 2;

    typedef enum logic [3:0] {
        IDLE,
        RD_HIT,
        WR_HIT,
        RD_MISS,
        RD_RELOAD,
        RD_WB,
        RD_ALLOCATE,
        WR_MISS,
        WR_RELOAD,
        WR_WB,
        WR_ALLOCATE
    } cache_state_e;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [7:0]        wmask;
        logic              rd_req;
        logic              wr_req;
    } cpu_req_t;

    // victim_addr and line_addr are line aligned
    typedef struct packed {
        logic                  hit;
        logic                  hit_way;
        logic                  victim_way;
        logic                  victim_dirty;
        logic [ADDR_W-1:0]     victim_addr;
        logic [ADDR_W-1:0]     line_addr;
        logic [WORD_SEL_W-1:0] word_sel;
    } lookup_t;

    // wr_hit_way is one-hot, bit per way
    typedef struct packed {
        logic                  fill_beat;
        logic                  capture;
        logic                  hit_read;
        logic [1:0]            wr_hit_way;
        logic                  allocate;
        logic [WORD_SEL_W-1:0] wb_beat;
    } store_ctrl_t;

    typedef struct packed {
        logic [ADDR_W-1:0] araddr;
        logic              arvalid;
    } mem_rd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [DATA_W-1:0] wdata;
        logic              wvalid;
        logic              wlast;
    } mem_wr_t;

endpackage

/* logic/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int SETS = 64
) (
    input  logic                          I_clk,
    input  logic                          I_rst,
    input  dcache_pkg::cpu_req_t          cpu_req,
    output logic                          cpu_ready,
    output logic                          cpu_rvalid,
    output logic                          cpu_bvalid,
    output logic [dcache_pkg::DATA_W-1:0] cpu_rdata,
    output dcache_pkg::mem_rd_t           mem_rd,
    input  logic                          arready,
    input  logic                          rvalid,
    input  logic                          rlast,
    input  logic [dcache_pkg::DATA_W-1:0] rdata,
    output dcache_pkg::mem_wr_t           mem_wr,
    input  logic                          awready,
    input  logic                          wready,
    input  logic                          bvalid
);
    import dcache_pkg::*;

    lookup_t           lookup;
    store_ctrl_t       ctrl;
    mem_wr_t           ctrl_wr;
    logic              accept;
    logic              allocate;
    logic              clean_victim;
    logic [DATA_W-1:0] wb_data;

    dcache_lookup #(
        .SETS(SETS)
    ) u_lookup (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .cpu_req      (cpu_req),
        .accept       (accept),
        .allocate     (allocate),
        .clean_victim (clean_victim),
        .lookup       (lookup)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .cpu_req      (cpu_req),
        .lookup       (lookup),
        .arready      (arready),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .accept       (accept),
        .cpu_ready    (cpu_ready),
        .cpu_rvalid   (cpu_rvalid),
        .cpu_bvalid   (cpu_bvalid),
        .allocate     (allocate),
        .clean_victim (clean_victim),
        .ctrl         (ctrl),
        .mem_rd       (mem_rd),
        .mem_wr       (ctrl_wr)
    );

    dcache_data_store #(
        .SETS(SETS)
    ) u_data_store (
        .I_clk     (I_clk),
        .I_rst     (I_rst),
        .cpu_req   (cpu_req),
        .lookup    (lookup),
        .ctrl      (ctrl),
        .rdata     (rdata),
        .cpu_rdata (cpu_rdata),
        .wb_data   (wb_data)
    );

    // victim beat data joins the write channel here
    assign mem_wr = '{awaddr:  ctrl_wr.awaddr,
                      awvalid: ctrl_wr.awvalid,
                      wdata:   wb_data,
                      wvalid:  ctrl_wr.wvalid,
                      wlast:   ctrl_wr.wlast};

endmodule

/* tests/dcache_golden.txt */
// op (0 read, 1 write)  addr  wdata  wmask  expected read data (0 for writes)
// untouched memory reads as {addr, ~addr}; sets are addr[10:5], tags addr[31:11]
0 00000100 0000000000000000 00 00000100FFFFFEFF
0 00000118 0000000000000000 00 00000118FFFFFEE7
1 00000208 1122334455667788 0F 0000000000000000
0 00000208 0000000000000000 00 0000020855667788
1 00000208 AABBCCDDEEFF0011 F0 0000000000000000
0 00000208 0000000000000000 00 AABBCCDD55667788
1 00000060 DEADBEEFCAFEF00D FF 0000000000000000
0 00000868 0000000000000000 00 00000868FFFFF797
0 00000060 0000000000000000 00 DEADBEEFCAFEF00D
0 00000870 0000000000000000 00 00000870FFFFF78F
0 00000068 0000000000000000 00 00000068FFFFFF97
0 00000878 0000000000000000 00 00000878FFFFF787
0 00001060 0000000000000000 00 00001060FFFFEF9F
0 00000060 0000000000000000 00 DEADBEEFCAFEF00D
0 00000868 0000000000000000 00 00000868FFFFF797
1 00000070 0F0E0D0C0B0A0908 3C 0000000000000000
1 00001078 0102030405060708 81 0000000000000000
0 00001078 0000000000000000 00 01001078FFFFEF08
0 00000070 0000000000000000 00 00000D0C0B0AFF8F
0 00001078 0000000000000000 00 01001078FFFFEF08
0 00000100 0000000000000000 00 00000100FFFFFEFF
0 00000870 0000000000000000 00 00000870FFFFF78F

/* tests/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int N_OPS    = 22;
    localparam int SETS     = 64;
    // refills and dirty evictions that the golden sequence causes
    localparam int EXP_AR   = 9;
    localparam int EXP_AW   = 3;
    localparam int WD_LIMIT = 2000 * N_OPS;

    logic              I_clk;
    logic              I_rst;
    cpu_req_t          cpu_req;
    logic              cpu_ready;
    logic              cpu_rvalid;
    logic              cpu_bvalid;
    logic [DATA_W-1:0] cpu_rdata;
    mem_rd_t           mem_rd;
    mem_wr_t           mem_wr;
    logic              arready;
    logic              rvalid;
    logic              rlast;
    logic [DATA_W-1:0] rdata;
    logic              awready;
    logic              wready;
    logic              bvalid;

    // five words per line: op, addr, wdata, wmask, expected read data
    logic [63:0]       gold [5*N_OPS];
    // sparse backing store, keyed by 8-byte aligned address
    logic [DATA_W-1:0] mem_store [logic [ADDR_W-1:0]];
    logic [15:0]       lfsr;
    int                errors;
    int                ar_count;
    int                aw_count;
    int                w_count;

    // memory model state
    logic              rd_active;
    logic [ADDR_W-1:0] rd_addr;
    int                rd_beat;
    logic              aw_seen;
    logic [ADDR_W-1:0] wr_addr;
    int                wr_beat;
    logic              b_pending;

    dcache_top #(
        .SETS(SETS)
    ) dut0 (
        .I_clk      (I_clk),
        .I_rst      (I_rst),
        .cpu_req    (cpu_req),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_bvalid (cpu_bvalid),
        .cpu_rdata  (cpu_rdata),
        .mem_rd     (mem_rd),
        .arready    (arready),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rdata      (rdata),
        .mem_wr     (mem_wr),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid)
    );

    always #2 I_clk = ~I_clk;

    // galois lfsr, one step per bit
    function automatic logic random_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    // untouched words hold the address and its inverse
    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        if (mem_store.exists(addr)) begin
            return mem_store[addr];
        end
        return {addr, ~addr};
    endfunction

    // handshakes that complete at the coming rising edge
    task automatic observe_handshakes();
        if (mem_rd.arvalid && arready) begin
            rd_active = 1'b1;
            rd_addr   = mem_rd.araddr;
            rd_beat   = 0;
            ar_count++;
        end
        if (rvalid) begin
            rd_beat++;
            if (rd_beat == BEATS) begin
                rd_active = 1'b0;
            end
        end
        if (bvalid) begin
            b_pending = 1'b0;
        end
        if (mem_wr.awvalid && awready) begin
            aw_seen = 1'b1;
            wr_addr = mem_wr.awaddr;
            wr_beat = 0;
            aw_count++;
        end
        if (mem_wr.wvalid && wready) begin
            if (!aw_seen) begin
                $display("write beat at %0t arrived without a write address", $time);
                errors++;
            end
            if (mem_wr.wlast !== (wr_beat == BEATS - 1)) begin
                $display("ERROR t=%0t mem_wr.wlast got %b expected %b",
                         $time, mem_wr.wlast, wr_beat == BEATS - 1);
                errors++;
            end
            mem_store[wr_addr + ADDR_W'(8 * wr_beat)] = mem_wr.wdata;
            wr_beat++;
            w_count++;
            if (wr_beat == BEATS) begin
                aw_seen   = 1'b0;
                b_pending = 1'b1;
            end
        end
    endtask

    always @(negedge I_clk) begin
        arready = random_bit();
        awready = random_bit();
        wready  = random_bit();
        rvalid  = 1'b0;
        if (rd_active) begin
            rvalid = random_bit();
        end
        rlast  = rvalid && (rd_beat == BEATS - 1);
        rdata  = rvalid ? read_word(rd_addr + ADDR_W'(8 * rd_beat)) : '0;
        bvalid = b_pending;
        #1;
        if (!I_rst) begin
            observe_handshakes();
        end
    end

    task automatic run_op(input int n);
        logic [63:0]       op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] expected;
        int                lat;
        int                ar_before;
        op       = gold[5*n];
        addr     = gold[5*n+1][ADDR_W-1:0];
        expected = gold[5*n+4];
        @(negedge I_clk);
        cpu_req.addr   = addr;
        cpu_req.wdata  = gold[5*n+2];
        cpu_req.wmask  = gold[5*n+3][7:0];
        cpu_req.rd_req = op == 0;
        cpu_req.wr_req = op == 1;
        #1;
        while (!cpu_ready) begin
            @(negedge I_clk);
            #1;
        end
        // accepted at the next rising edge
        ar_before = ar_count;
        @(negedge I_clk);
        cpu_req.rd_req = 1'b0;
        cpu_req.wr_req = 1'b0;
        lat = 1;
        #1;
        while (!(op == 0 ? cpu_rvalid : cpu_bvalid)) begin
            @(negedge I_clk);
            #1;
            lat++;
        end
        if (op == 0 && cpu_rdata !== expected) begin
            $display("ERROR t=%0t cpu_rdata got %h expected %h at address %h",
                     $time, cpu_rdata, expected, addr);
            errors++;
        end
        // no refill means a hit, answered one cycle after acceptance
        if (ar_count == ar_before && (lat != 1 || !cpu_ready)) begin
            $display("hit at address %h took %0d cycles or dropped cpu_ready", addr, lat);
            errors++;
        end
    endtask

    initial begin
        I_clk     = 1'b0;
        I_rst     = 1'b1;
        cpu_req   = '0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        rdata     = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        lfsr      = 16'd61;
        errors    = 0;
        ar_count  = 0;
        aw_count  = 0;
        w_count   = 0;
        rd_active = 1'b0;
        rd_addr   = '0;
        rd_beat   = 0;
        aw_seen   = 1'b0;
        wr_addr   = '0;
        wr_beat   = 0;
        b_pending = 1'b0;
        $readmemh("tests/dcache_golden.txt", gold);
        repeat (16) @(posedge I_clk);
        @(negedge I_clk);
        I_rst = 1'b0;
        for (int n = 0; n < N_OPS; n++) begin
            run_op(n);
        end
        @(negedge I_clk);
        if (ar_count != EXP_AR) begin
            $display("ERROR t=%0t mem_rd refills got %0d expected %0d", $time, ar_count, EXP_AR);
            errors++;
        end
        if (aw_count != EXP_AW) begin
            $display("ERROR t=%0t mem_wr write-backs got %0d expected %0d",
                     $time, aw_count, EXP_AW);
            errors++;
        end
        if (w_count != BEATS * EXP_AW) begin
            $display("ERROR t=%0t mem_wr beats got %0d expected %0d",
                     $time, w_count, BEATS * EXP_AW);
            errors++;
        end
        $display("%0d operations, %0d refills, %0d write-backs, %0d errors",
                 N_OPS, ar_count, aw_count, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WD_LIMIT + 16) @(posedge I_clk);
        $display("watchdog expired after %0d cycles with operations still pending", WD_LIMIT);
        $display("Simulation failed");
        $finish;
    end

endmodule
